//--- verilog/cpu_pkg.sv
package cpu_pkg;

    // Opcode numbering follows the original ALU.
    typedef enum logic [5:0] {
        op_add  = 6'd0,
        op_sub  = 6'd1,
        op_shl  = 6'd2,
        op_shr  = 6'd3,
        op_mov  = 6'd4,
        op_ldh  = 6'd5,
        op_ceq  = 6'd8,
        op_clt  = 6'd9,
        op_cgt  = 6'd10,
        op_jmp  = 6'd14,
        op_jft  = 6'd15,
        op_halt = 6'd63
    } alu_op_t;

    typedef enum logic [2:0] {
        st_idle,
        st_fetch,
        st_decode,
        st_execute,
        st_writeback,
        st_halted
    } state_t;

    typedef struct packed {
        alu_op_t     op;
        logic [3:0]  rd;
        logic [3:0]  ra;
        logic [3:0]  rb;
        logic        highlow;   // Selects upper half for ldh.
        logic        spare;
        logic [15:0] value;
    } instr_t;

    typedef struct packed {
        logic [31:0] result;
        logic        write_en;
        logic        flag_en;
        logic        flag_val;
        logic        jump;
    } alu_out_t;

    localparam logic [3:0] jump_reg = 4'd8;   // Holds jump targets.

endpackage

//--- verilog/alu.sv
`timescale 1ns/1ps

module alu (
    input  cpu_pkg::instr_t   ir,
    input  logic [31:0]       a,
    input  logic [31:0]       b,
    input  logic              flag,
    output cpu_pkg::alu_out_t res
);

    logic [31:0] sum;
    logic [31:0] diff;
    logic [31:0] shl_ones;
    logic [31:0] shr_ones;
    logic [31:0] half_load;
    logic        big_shift;

    assign sum  = a + b;
    assign diff = a - b;

    // Shift amounts of 32 or more leave every bit set.
    assign big_shift = |b[31:5];
    assign shl_ones  = big_shift ? '1 : ~(~a << b[4:0]);
    assign shr_ones  = big_shift ? '1 : ~(~a >> b[4:0]);

    assign half_load = ir.highlow ? {ir.value, a[15:0]} : {a[31:16], ir.value};

    always_comb
    begin
        res = '0;
        case (ir.op)
            cpu_pkg::op_add:
            begin
                res.result   = sum;
                res.write_en = 1'b1;
            end
            cpu_pkg::op_sub:
            begin
                res.result   = diff;
                res.write_en = 1'b1;
            end
            cpu_pkg::op_shl:
            begin
                res.result   = shl_ones;
                res.write_en = 1'b1;
            end
            cpu_pkg::op_shr:
            begin
                res.result   = shr_ones;
                res.write_en = 1'b1;
            end
            cpu_pkg::op_mov:
            begin
                res.result   = a;
                res.write_en = 1'b1;
            end
            cpu_pkg::op_ldh:
            begin
                res.result   = half_load;
                res.write_en = 1'b1;
            end
            // Compares are unsigned.
            cpu_pkg::op_ceq:
            begin
                res.flag_en  = 1'b1;
                res.flag_val = (a == b);
            end
            cpu_pkg::op_clt:
            begin
                res.flag_en  = 1'b1;
                res.flag_val = (a < b);
            end
            cpu_pkg::op_cgt:
            begin
                res.flag_en  = 1'b1;
                res.flag_val = (a > b);
            end
            cpu_pkg::op_jmp:
            begin
                res.jump = 1'b1;
            end
            cpu_pkg::op_jft:
            begin
                res.jump = flag;   // Taken only on a set flag.
            end
            default:
            begin
                res = '0;   // Halt and unknown opcodes.
            end
        endcase
    end

endmodule

//--- verilog/control_fsm.sv
`timescale 1ns/1ps

module control_fsm #(
    parameter int PROG_DEPTH = 64,
    parameter int PC_W       = 6
) (
    input  logic              clock,
    input  logic              rst,
    input  logic              start,
    input  cpu_pkg::instr_t   instr,
    input  cpu_pkg::alu_out_t alu_res,
    input  logic [31:0]       r8_data,
    output logic              pc_inc,
    output logic              pc_load,
    output logic              pc_clear,
    output logic [PC_W-1:0]   pc_target,
    output cpu_pkg::instr_t   ir,
    output logic              wr_en,
    output logic [3:0]        wr_addr,
    output logic [31:0]       wr_data,
    output logic              flag,
    output logic              halted,
    output logic [15:0]       retired
);

    cpu_pkg::state_t   state;
    cpu_pkg::state_t   state_nxt;
    cpu_pkg::alu_out_t res_q;
    logic [PC_W-1:0]   target_q;
    logic              start_ok;
    logic              in_wb;

    if (PROG_DEPTH > (1 << PC_W))
    begin : g_depth_check
        $error("PROG_DEPTH does not fit in PC_W address bits.");
    end

    assign start_ok = start && (state == cpu_pkg::st_idle || state == cpu_pkg::st_halted);
    assign in_wb    = (state == cpu_pkg::st_writeback);

    always_comb
    begin
        state_nxt = state;
        case (state)
            cpu_pkg::st_idle,
            cpu_pkg::st_halted:
            begin
                if (start)
                    state_nxt = cpu_pkg::st_fetch;
            end
            cpu_pkg::st_fetch:   state_nxt = cpu_pkg::st_decode;
            cpu_pkg::st_decode:  state_nxt = cpu_pkg::st_execute;
            cpu_pkg::st_execute: state_nxt = cpu_pkg::st_writeback;
            cpu_pkg::st_writeback:
            begin
                if (ir.op == cpu_pkg::op_halt)
                    state_nxt = cpu_pkg::st_halted;
                else
                    state_nxt = cpu_pkg::st_fetch;
            end
            default: state_nxt = cpu_pkg::st_idle;
        endcase
    end

    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            state   <= cpu_pkg::st_idle;
            flag    <= 1'b0;
            retired <= '0;
            res_q   <= '0;
        end
        else
        begin
            state <= state_nxt;
            if (start_ok)
                retired <= '0;   // Rerun counts afresh.
            if (state == cpu_pkg::st_execute)
                res_q <= alu_res;
            if (in_wb)
            begin
                retired <= retired + 16'd1;
                if (res_q.flag_en)
                    flag <= res_q.flag_val;
            end
        end
    end

    // Instruction and jump target.
    always_ff @(posedge clock)
    begin
        if (state == cpu_pkg::st_decode)
            ir <= instr;
        if (state == cpu_pkg::st_execute)
            target_q <= r8_data[PC_W-1:0];
    end

    assign pc_clear  = start_ok;
    assign pc_load   = in_wb && res_q.jump;
    assign pc_inc    = in_wb && !res_q.jump;
    assign pc_target = target_q;

    assign wr_en   = in_wb && res_q.write_en;
    assign wr_addr = ir.rd;
    assign wr_data = res_q.result;
    assign halted  = (state == cpu_pkg::st_halted);

    // A pc move comes right after execute and follows its jump request.
    a_pc_move_excl: assert property (@(posedge clock) disable iff (rst)
        (pc_load || pc_inc) |->
            $past(state == cpu_pkg::st_execute) && (pc_load == $past(alu_res.jump)));

    a_write_in_wb: assert property (@(posedge clock) disable iff (rst)
        wr_en |-> $past(state == cpu_pkg::st_execute && alu_res.write_en));

endmodule

//--- verilog/program_counter.sv
`timescale 1ns/1ps

module program_counter #(
    parameter int PROG_DEPTH = 64,
    parameter int PC_W       = 6
) (
    input  logic            clock,
    input  logic            rst,
    input  logic            clear,
    input  logic            inc,
    input  logic            load,
    input  logic [PC_W-1:0] target,
    output logic [PC_W-1:0] pc
);

    logic [PC_W-1:0] pc_next_seq;

    // Wraps after the last memory word.
    assign pc_next_seq = (pc == PC_W'(PROG_DEPTH - 1)) ? '0 : pc + 1'b1;

    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            pc <= '0;
        end
        else if (clear)
        begin
            pc <= '0;   // Start of a run.
        end
        else if (load)
        begin
            pc <= target;
        end
        else if (inc)
        begin
            pc <= pc_next_seq;
        end
    end

    a_no_load_on_clear: assert property (@(posedge clock) disable iff (rst)
        !(load && clear));

endmodule

//--- verilog/register_file.sv
`timescale 1ns/1ps

module register_file (
    input  logic        clock,
    input  logic        rst,
    input  logic        wr_en,
    input  logic [3:0]  wr_addr,
    input  logic [31:0] wr_data,
    input  logic [3:0]  ra,
    input  logic [3:0]  rb,
    output logic [31:0] a_data,
    output logic [31:0] b_data,
    output logic [31:0] r8_data,
    input  logic [3:0]  dbg_addr,
    output logic [31:0] dbg_data
);

    logic [31:0] regs [16];

    always_ff @(posedge clock)
    begin
        if (rst)
        begin
            for (int i = 0; i < 16; i++)
            begin
                regs[i] <= '0;
            end
        end
        else if (wr_en)
        begin
            regs[wr_addr] <= wr_data;
        end
    end

    // Asynchronous reads.
    assign a_data   = regs[ra];
    assign b_data   = regs[rb];
    assign r8_data  = regs[cpu_pkg::jump_reg];   // Jump target.
    assign dbg_data = regs[dbg_addr];

endmodule

//--- verilog/program_memory.sv
`timescale 1ns/1ps

module program_memory #(
    parameter int PROG_DEPTH = 64,
    parameter int PC_W       = 6
) (
    input  logic            clock,
    input  logic            we,
    input  logic [PC_W-1:0] waddr,
    input  cpu_pkg::instr_t wdata,
    input  logic [PC_W-1:0] raddr,
    output cpu_pkg::instr_t rdata
);

    cpu_pkg::instr_t mem [PROG_DEPTH];

    always_ff @(posedge clock)
    begin
        if (we)
            mem[waddr] <= wdata;   // Loaded from outside.
    end

    // One cycle read latency.
    always_ff @(posedge clock)
    begin
        rdata <= mem[raddr];
    end

endmodule

//--- verilog/cpu_top.sv
`timescale 1ns/1ps

module cpu_top #(
    parameter int PROG_DEPTH = 64,
    parameter int PC_W       = 6
) (
    input  logic            clock,
    input  logic            rst,
    input  logic            start,
    input  logic            prog_we,
    input  logic [PC_W-1:0] prog_addr,
    input  cpu_pkg::instr_t prog_data,
    input  logic [3:0]      dbg_addr,
    output logic [31:0]     dbg_data,
    output logic            halted,
    output logic            flag,
    output logic [15:0]     retired,
    output logic [PC_W-1:0] pc
);

    cpu_pkg::instr_t   mem_rdata;
    cpu_pkg::instr_t   ir;
    cpu_pkg::alu_out_t alu_res;
    logic              pc_inc;
    logic              pc_load;
    logic              pc_clear;
    logic [PC_W-1:0]   pc_target;
    logic              wr_en;
    logic [3:0]        wr_addr;
    logic [31:0]       wr_data;
    logic [31:0]       a_data;
    logic [31:0]       b_data;
    logic [31:0]       r8_data;

    control_fsm #(
        .PROG_DEPTH (PROG_DEPTH),
        .PC_W       (PC_W)
    ) control_fsm_inst (
        .clock     (clock),
        .rst       (rst),
        .start     (start),
        .instr     (mem_rdata),
        .alu_res   (alu_res),
        .r8_data   (r8_data),
        .pc_inc    (pc_inc),
        .pc_load   (pc_load),
        .pc_clear  (pc_clear),
        .pc_target (pc_target),
        .ir        (ir),
        .wr_en     (wr_en),
        .wr_addr   (wr_addr),
        .wr_data   (wr_data),
        .flag      (flag),
        .halted    (halted),
        .retired   (retired)
    );

    program_counter #(
        .PROG_DEPTH (PROG_DEPTH),
        .PC_W       (PC_W)
    ) program_counter_inst (
        .clock  (clock),
        .rst    (rst),
        .clear  (pc_clear),
        .inc    (pc_inc),
        .load   (pc_load),
        .target (pc_target),
        .pc     (pc)
    );

    program_memory #(
        .PROG_DEPTH (PROG_DEPTH),
        .PC_W       (PC_W)
    ) program_memory_inst (
        .clock (clock),
        .we    (prog_we),
        .waddr (prog_addr),
        .wdata (prog_data),
        .raddr (pc),
        .rdata (mem_rdata)
    );

    register_file register_file_inst (
        .clock    (clock),
        .rst      (rst),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .ra       (ir.ra),
        .rb       (ir.rb),
        .a_data   (a_data),
        .b_data   (b_data),
        .r8_data  (r8_data),
        .dbg_addr (dbg_addr),
        .dbg_data (dbg_data)
    );

    alu alu_inst (
        .ir   (ir),
        .a    (a_data),
        .b    (b_data),
        .flag (flag),
        .res  (alu_res)
    );

endmodule

//--- verification/tb_cpu_model.svh
`ifndef TB_CPU_MODEL_SVH
`define TB_CPU_MODEL_SVH

typedef struct packed {
    logic [15:0][31:0] regs;
    logic              flag;
    logic [15:0]       count;
    logic [PC_W-1:0]   pc;
} model_state_t;

// One bit position per step, vacated bits become ones.
function automatic logic [31:0] ones_fill_shift(logic [31:0] val, logic [31:0] amount, bit left);
    for (int i = 0; i < 32; i++)
    begin
        if (i < amount)
            val = left ? {val[30:0], 1'b1} : {1'b1, val[31:1]};
    end
    return val;
endfunction

// Executes prog_img from address 0 until halt, starting from the given state.
function automatic model_state_t run_model(input model_state_t init);
    model_state_t    s;
    cpu_pkg::instr_t ins;
    logic [31:0]     a;
    logic [31:0]     b;
    bit              jump;
    bit              done;
    int              steps;
    s     = init;
    s.pc  = '0;
    s.count = '0;
    done  = 1'b0;
    steps = 0;
    while (!done && steps < STEP_LIMIT)
    begin
        ins     = prog_img[s.pc];
        a       = s.regs[ins.ra];
        b       = s.regs[ins.rb];
        jump    = 1'b0;
        s.count = s.count + 16'd1;   // Halt counts too.
        steps++;
        case (ins.op)
            cpu_pkg::op_add: s.regs[ins.rd] = a + b;
            cpu_pkg::op_sub: s.regs[ins.rd] = a - b;
            cpu_pkg::op_shl: s.regs[ins.rd] = ones_fill_shift(a, b, 1'b1);
            cpu_pkg::op_shr: s.regs[ins.rd] = ones_fill_shift(a, b, 1'b0);
            cpu_pkg::op_mov: s.regs[ins.rd] = a;
            cpu_pkg::op_ldh:
            begin
                if (ins.highlow)
                    s.regs[ins.rd] = {ins.value, a[15:0]};
                else
                    s.regs[ins.rd] = {a[31:16], ins.value};
            end
            cpu_pkg::op_ceq: s.flag = (a == b);
            cpu_pkg::op_clt: s.flag = (a < b);
            cpu_pkg::op_cgt: s.flag = (a > b);
            cpu_pkg::op_jmp: jump = 1'b1;
            cpu_pkg::op_jft: jump = s.flag;
            cpu_pkg::op_halt: done = 1'b1;
            default: ;
        endcase
        if (jump)
            s.pc = s.regs[8][PC_W-1:0];
        else if (int'(s.pc) == PROG_DEPTH - 1)
            s.pc = '0;   // Wraps at the end of memory.
        else
            s.pc = s.pc + 1'b1;
    end
    return s;
endfunction

`endif

//--- verification/tb_cpu.sv
`timescale 1ns/1ps

module tb_cpu;

    localparam int PROG_DEPTH = 64;
    localparam int PC_W       = 6;
    localparam int NUM_RUNS   = 13;
    localparam int STEP_LIMIT = 1024;
    // Budget per run covers 64 instructions plus loading and readback.
    localparam int WATCHDOG_NS = NUM_RUNS * (64 * 4 + 64 + 40) * 4 + 500;

    logic              clock;
    logic              rst;
    logic              start;
    logic              prog_we;
    logic [PC_W-1:0]   prog_addr;
    cpu_pkg::instr_t   prog_data;
    logic [3:0]        dbg_addr;
    logic [31:0]       dbg_data;
    logic              halted;
    logic              flag;
    logic [15:0]       retired;
    logic [PC_W-1:0]   pc;

    cpu_pkg::instr_t   prog_img [PROG_DEPTH];
    cpu_pkg::alu_op_t  arith_ops [3];
    cpu_pkg::alu_op_t  cmp_ops [3];
    int                shift_amounts [6];
    int                seed = 32'h7244_4a17;
    int                error_count = 0;

    `include "tb_cpu_model.svh"

    model_state_t exp_state;

    cpu_top #(
        .PROG_DEPTH (PROG_DEPTH),
        .PC_W       (PC_W)
    ) cpu_top_inst (
        .clock     (clock),
        .rst       (rst),
        .start     (start),
        .prog_we   (prog_we),
        .prog_addr (prog_addr),
        .prog_data (prog_data),
        .dbg_addr  (dbg_addr),
        .dbg_data  (dbg_data),
        .halted    (halted),
        .flag      (flag),
        .retired   (retired),
        .pc        (pc)
    );

    initial
    begin
        clock = 1'b0;
        forever #2 clock = ~clock;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Timeout: the machine did not halt within the time limit.");
        $display("Simulation failed");
        $finish;
    end

    task automatic check(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp)
        begin
            error_count++;
            $display("[ERROR] %0t ns: %s read %h, expected %h", $time, what, got, exp);
        end
    endtask

    function automatic cpu_pkg::instr_t enc(cpu_pkg::alu_op_t op, int rd, int ra, int rb,
                                            bit hl, logic [15:0] value);
        cpu_pkg::instr_t ins;
        ins         = '0;
        ins.op      = op;
        ins.rd      = rd[3:0];
        ins.ra      = ra[3:0];
        ins.rb      = rb[3:0];
        ins.highlow = hl;
        ins.value   = value;
        return ins;
    endfunction

    // Unused words hold halts tagged with their address.
    task automatic clear_image();
        for (int a = 0; a < PROG_DEPTH; a++)
            prog_img[a] = enc(cpu_pkg::op_halt, a, 0, 0, 1'b0, 16'(a * 257));
    endtask

    task automatic load_const(inout int addr, input int rd, input logic [31:0] val);
        prog_img[addr] = enc(cpu_pkg::op_ldh, rd, rd, 0, 1'b1, val[31:16]);
        prog_img[addr + 1] = enc(cpu_pkg::op_ldh, rd, rd, 0, 1'b0, val[15:0]);
        addr += 2;
    endtask

    task automatic load_program();
        for (int a = 0; a < PROG_DEPTH; a++)
        begin
            @(negedge clock);
            prog_we   = 1'b1;
            prog_addr = a[PC_W-1:0];
            prog_data = prog_img[a];
        end
        @(negedge clock);
        prog_we = 1'b0;
    endtask

    task automatic compare_state(input string name, input bit exp_halted);
        for (int i = 0; i < 16; i++)
        begin
            @(negedge clock);
            dbg_addr = i[3:0];
            #1;
            check($sformatf("%s r%0d", name, i), dbg_data, exp_state.regs[i]);
        end
        check({name, " halted"}, {31'd0, halted}, {31'd0, exp_halted});
        check({name, " flag"}, {31'd0, flag}, {31'd0, exp_state.flag});
        check({name, " retired"}, {16'd0, retired}, {16'd0, exp_state.count});
        check({name, " pc"}, 32'(pc), 32'(exp_state.pc));
    endtask

    task automatic run_and_compare(input string name);
        exp_state = run_model(exp_state);
        @(negedge clock);
        start = 1'b1;
        @(negedge clock);
        start = 1'b0;
        check({name, " running"}, {31'd0, halted}, 32'd0);   // Start was accepted.
        while (!halted)
            @(negedge clock);
        compare_state(name, 1'b1);
    endtask

    initial
    begin : main_seq
        int          addr;
        int          t;
        logic [31:0] va;
        logic [31:0] vb;
        logic [31:0] delta;
        rst       = 1'b1;
        start     = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        dbg_addr  = '0;
        exp_state = '0;
        arith_ops = '{cpu_pkg::op_add, cpu_pkg::op_sub, cpu_pkg::op_mov};
        cmp_ops   = '{cpu_pkg::op_ceq, cpu_pkg::op_clt, cpu_pkg::op_cgt};
        shift_amounts = '{0, 1, 31, 32, 0, 0};
        repeat (3) @(negedge clock);
        rst = 1'b0;
        compare_state("reset", 1'b0);

        clear_image();
        addr = 0;
        for (int r = 1; r <= 6; r++)
            load_const(addr, r, $random(seed));
        repeat (10)
        begin
            t = $random(seed);
            prog_img[addr] = enc(arith_ops[(t >> 12) % 3], t & 15, (t >> 4) & 15,
                                 (t >> 8) & 15, 1'b0, 16'd0);
            addr++;
        end
        load_program();
        run_and_compare("arith");

        clear_image();
        addr = 0;
        shift_amounts[4] = $random(seed) & 63;
        shift_amounts[5] = $random(seed);
        load_const(addr, 1, $random(seed));
        for (int k = 0; k < 6; k++)
        begin
            load_const(addr, 2, shift_amounts[k]);
            prog_img[addr] = enc(cpu_pkg::op_shl, 3 + 2 * k, 1, 2, 1'b0, 16'd0);
            prog_img[addr + 1] = enc(cpu_pkg::op_shr, 4 + 2 * k, 1, 2, 1'b0, 16'd0);
            addr += 2;
        end
        load_program();
        run_and_compare("shift");

        // Equal, smaller and larger pairs for each compare.
        for (int c = 0; c < 9; c++)
        begin
            va    = $random(seed);
            va    = {2'b01, va[29:0]};
            delta = ($random(seed) & 32'hfff) + 32'd1;
            vb    = (c % 3 == 0) ? va : ((c % 3 == 1) ? va + delta : va - delta);
            clear_image();
            addr = 0;
            load_const(addr, 1, va);
            load_const(addr, 2, vb);
            prog_img[addr] = enc(cmp_ops[c / 3], 0, 1, 2, 1'b0, 16'd0);
            load_program();
            run_and_compare($sformatf("compare %0d", c));
        end

        clear_image();
        addr = 0;
        load_const(addr, 1, 32'd5);    // Loop counter.
        load_const(addr, 2, 32'd1);
        load_const(addr, 3, 32'd0);
        load_const(addr, 8, 32'd10);   // Loop top.
        load_const(addr, 4, 32'd0);
        prog_img[10] = enc(cpu_pkg::op_add, 4, 4, 1, 1'b0, 16'd0);
        prog_img[11] = enc(cpu_pkg::op_sub, 1, 1, 2, 1'b0, 16'd0);
        prog_img[12] = enc(cpu_pkg::op_cgt, 0, 1, 3, 1'b0, 16'd0);
        prog_img[13] = enc(cpu_pkg::op_jft, 0, 0, 0, 1'b0, 16'd0);
        addr = 14;
        load_const(addr, 8, 32'd19);
        prog_img[16] = enc(cpu_pkg::op_jmp, 0, 0, 0, 1'b0, 16'd0);
        prog_img[17] = enc(cpu_pkg::op_ldh, 5, 5, 0, 1'b0, 16'hdead);
        prog_img[18] = enc(cpu_pkg::op_ldh, 6, 6, 0, 1'b0, 16'hbeef);
        prog_img[19] = enc(cpu_pkg::op_ceq, 0, 1, 3, 1'b0, 16'd0);
        prog_img[20] = enc(cpu_pkg::op_clt, 0, 3, 1, 1'b0, 16'd0);
        prog_img[21] = enc(cpu_pkg::op_jft, 0, 0, 0, 1'b0, 16'd0);
        load_program();
        run_and_compare("jump");
        run_and_compare("rerun");

        $display("Checks finished with %0d errors.", error_count);
        if (error_count == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

//--- list.f
+incdir+verification
verilog/cpu_pkg.sv
verilog/alu.sv
verilog/control_fsm.sv
verilog/program_counter.sv
verilog/register_file.sv
verilog/program_memory.sv
verilog/cpu_top.sv
verification/tb_cpu.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f list.f --top-module tb_cpu -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed."
    exit 1
fi

output=$(./obj_dir/Vtb_cpu)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
    echo "Simulation run returned an error status."
    exit 1
fi

if printf '%s\n' "$output" | grep -qx "Simulation passed"; then
    exit 0
fi
exit 1
